//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_pipe
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TEST RESULT: FAIL

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
logic/mem_pkg.sv
logic/core_pkg.sv
logic/muldiv_unit.sv
logic/ex_stage.sv
logic/ex_mem_regs.sv
logic/mem_stage.sv
logic/exec_pipe_top.sv
verification/exec_pipe_checker.sv
verification/tb_exec_pipe.sv

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;
	import mem_pkg::*;

	localparam int XLEN          = 64;
	localparam int REG_ADDR_W    = 5;
	localparam int MULDIV_CYCLES = 64;                      // one bit per step
	localparam int MULDIV_CNT_W  = $clog2(MULDIV_CYCLES);

	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
		OP_MUL, OP_DIVU, OP_REMU,                       // multicycle unit
		OP_LOAD, OP_STORE
	} alu_op_e;

	// decoded instruction as handed to execute
	typedef struct packed {
		alu_op_e                op;
		logic [XLEN-1:0]        src1;
		logic [XLEN-1:0]        src2;
		logic [31:0]            imm;            // sign extended in ex
		logic [REG_ADDR_W-1:0]  rd;
		logic                   reg_wen;
		mem_size_e              mem_size;
		logic                   load_signed;
	} issue_t;

	typedef struct packed {
		logic                   valid;
		alu_op_e                op;
		logic [XLEN-1:0]        result;         // alu result or address
		logic [XLEN-1:0]        store_data;
		logic [REG_ADDR_W-1:0]  rd;
		logic                   reg_wen;
		mem_size_e              mem_size;
		logic                   load_signed;
	} ex_mem_t;

	function automatic logic is_muldiv(alu_op_e op);
		return op inside {OP_MUL, OP_DIVU, OP_REMU};
	endfunction

endpackage

`default_nettype wire

//--- logic/ex_mem_regs.sv
`timescale 1ns/1ps
`default_nettype none

// EX/MEM register, bubbles come in from ex_stage during a stall
module ex_mem_regs import core_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  ex_mem_t ex_i,
	output ex_mem_t mem_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_o <= '0;
		else
			mem_o <= ex_i;
	end

	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		mem_o.valid |-> !$isunknown(mem_o.op) && !$isunknown(mem_o.result))
		else $error("ex_mem_regs: valid entry with unknown op or result");

	// a muldiv result passes exactly once, never held over a second cycle
	a_md_once: assert property (@(posedge clk) disable iff (!rst_n)
		mem_o.valid && is_muldiv(mem_o.op) |=> !(mem_o.valid && is_muldiv(mem_o.op)))
		else $error("ex_mem_regs: multicycle result repeated");

endmodule

`default_nettype wire

//--- logic/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import core_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    issue_valid_i,
	input  issue_t  issue_i,
	output ex_mem_t ex_o,
	output logic    stall_o
);

	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] md_result;
	logic [5:0]      shamt;
	logic            md_start;
	logic            md_busy;
	logic            md_done;
	logic            md_active;
	issue_t          md_issue;     // muldiv op waiting for its result
	issue_t          sel;

	assign imm_ext  = {{(XLEN-32){issue_i.imm[31]}}, issue_i.imm};
	assign shamt    = issue_i.src2[5:0];
	assign stall_o  = md_busy | md_done;   // done cycle owns the ex output
	assign md_start = issue_valid_i && !stall_o && is_muldiv(issue_i.op);

	always_comb begin
		case (issue_i.op)
			OP_ADD:   alu_res = issue_i.src1 + issue_i.src2;
			OP_SUB:   alu_res = issue_i.src1 - issue_i.src2;
			OP_AND:   alu_res = issue_i.src1 & issue_i.src2;
			OP_OR:    alu_res = issue_i.src1 | issue_i.src2;
			OP_XOR:   alu_res = issue_i.src1 ^ issue_i.src2;
			OP_SLL:   alu_res = issue_i.src1 << shamt;
			OP_SRL:   alu_res = issue_i.src1 >> shamt;
			OP_SRA:   alu_res = $unsigned($signed(issue_i.src1) >>> shamt);
			OP_SLT:   alu_res = {{(XLEN-1){1'b0}},
			                     $signed(issue_i.src1) < $signed(issue_i.src2)};
			OP_SLTU:  alu_res = {{(XLEN-1){1'b0}}, issue_i.src1 < issue_i.src2};
			OP_LOAD,
			OP_STORE: alu_res = issue_i.src1 + imm_ext;   // effective address
			default:  alu_res = '0;
		endcase
	end

	muldiv_unit u_muldiv (
		.clk      (clk),
		.rst_n    (rst_n),
		.start_i  (md_start),
		.op_i     (issue_i.op),
		.a_i      (issue_i.src1),
		.b_i      (issue_i.src2),
		.busy_o   (md_busy),
		.done_o   (md_done),
		.result_o (md_result)
	);

	always_ff @(posedge clk) begin
		if (md_start)
			md_issue <= issue_i;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			md_active <= 1'b0;
		else if (md_start)
			md_active <= 1'b1;
		else if (md_done)
			md_active <= 1'b0;
	end

	assign sel = md_done ? md_issue : issue_i;

	// bubble while the unit is running
	always_comb begin
		ex_o.valid       = md_done || (issue_valid_i && !stall_o && !is_muldiv(issue_i.op));
		ex_o.op          = sel.op;
		ex_o.result      = md_done ? md_result : alu_res;
		ex_o.store_data  = sel.src2;
		ex_o.rd          = sel.rd;
		ex_o.reg_wen     = sel.reg_wen;
		ex_o.mem_size    = sel.mem_size;
		ex_o.load_signed = sel.load_signed;
	end

	a_stall_owner: assert property (@(posedge clk) disable iff (!rst_n)
		stall_o |-> md_active)
		else $error("ex_stage: stall without a multicycle op");

endmodule

`default_nettype wire

//--- logic/exec_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

// execute, EX/MEM and memory with registered writeback
module exec_pipe_top import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue_valid_i,
	input  issue_t                issue_i,
	output logic                  stall_o,
	output logic                  wb_valid_o,
	output logic                  wb_wen_o,
	output logic [REG_ADDR_W-1:0] wb_rd_o,
	output logic [XLEN-1:0]       wb_data_o
);

	ex_mem_t ex_out;    // comb ex result
	ex_mem_t mem_in;    // registered

	ex_stage u_ex (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid_i),
		.issue_i       (issue_i),
		.ex_o          (ex_out),
		.stall_o       (stall_o)
	);

	ex_mem_regs u_ex_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.ex_i  (ex_out),
		.mem_o (mem_in)
	);

	mem_stage u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_i      (mem_in),
		.wb_valid_o (wb_valid_o),
		.wb_wen_o   (wb_wen_o),
		.wb_rd_o    (wb_rd_o),
		.wb_data_o  (wb_data_o)
	);

endmodule

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

// data memory geometry and access encodings
package mem_pkg;

	localparam int DMEM_WORDS = 256;      // double words
	localparam int DMEM_AW    = 8;        // word index width
	localparam int DMEM_LANES = 8;        // bytes per word
	localparam int BYTE_OFF_W = 3;        // byte offset inside a word

	// access size as seen on the load/store path
	typedef enum logic [1:0] {
		MEM_BYTE   = 2'd0,
		MEM_HALF   = 2'd1,
		MEM_WORD   = 2'd2,
		MEM_DOUBLE = 2'd3
	} mem_size_e;

	// what the memory stage does this cycle
	typedef enum logic [1:0] {
		MEM_NONE = 2'd0,
		MEM_RD   = 2'd1,
		MEM_WR   = 2'd2
	} mem_cmd_e;

endpackage

`default_nettype wire

//--- logic/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import core_pkg::*; import mem_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  ex_mem_t               mem_i,
	output logic                  wb_valid_o,
	output logic                  wb_wen_o,
	output logic [REG_ADDR_W-1:0] wb_rd_o,
	output logic [XLEN-1:0]       wb_data_o
);

	logic [XLEN-1:0]       dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0]    word_idx;
	logic [BYTE_OFF_W-1:0] byte_off;
	logic [DMEM_LANES-1:0] size_mask;
	logic [DMEM_LANES-1:0] byte_mask;
	logic [XLEN-1:0]       wdata_sh;
	logic [XLEN-1:0]       rdata_sh;
	logic [XLEN-1:0]       load_data;
	logic                  aligned;
	mem_cmd_e              cmd;

	assign word_idx = mem_i.result[DMEM_AW+BYTE_OFF_W-1:BYTE_OFF_W];
	assign byte_off = mem_i.result[BYTE_OFF_W-1:0];

	always_comb begin
		if (!mem_i.valid)
			cmd = MEM_NONE;
		else if (mem_i.op == OP_LOAD)
			cmd = MEM_RD;
		else if (mem_i.op == OP_STORE)
			cmd = MEM_WR;
		else
			cmd = MEM_NONE;
	end

	always_comb begin
		case (mem_i.mem_size)
			MEM_BYTE: begin
				size_mask = 8'h01;
				aligned   = 1'b1;
			end
			MEM_HALF: begin
				size_mask = 8'h03;
				aligned   = (byte_off[0] == 1'b0);
			end
			MEM_WORD: begin
				size_mask = 8'h0f;
				aligned   = (byte_off[1:0] == 2'b00);
			end
			default: begin
				size_mask = 8'hff;
				aligned   = (byte_off == '0);
			end
		endcase
	end

	// move data into / out of the addressed lanes
	assign byte_mask = size_mask << byte_off;
	assign wdata_sh  = mem_i.store_data << {byte_off, 3'b000};
	assign rdata_sh  = dmem[word_idx] >> {byte_off, 3'b000};

	always_ff @(posedge clk) begin
		if (cmd == MEM_WR) begin
			for (int i = 0; i < DMEM_LANES; i++) begin
				if (byte_mask[i])
					dmem[word_idx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
			end
		end
	end

	always_comb begin
		case (mem_i.mem_size)
			MEM_BYTE: load_data = {{(XLEN-8){mem_i.load_signed & rdata_sh[7]}}, rdata_sh[7:0]};
			MEM_HALF: load_data = {{(XLEN-16){mem_i.load_signed & rdata_sh[15]}}, rdata_sh[15:0]};
			MEM_WORD: load_data = {{(XLEN-32){mem_i.load_signed & rdata_sh[31]}}, rdata_sh[31:0]};
			default:  load_data = rdata_sh;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_o <= 1'b0;
			wb_wen_o   <= 1'b0;
		end else begin
			wb_valid_o <= mem_i.valid;
			wb_wen_o   <= mem_i.valid && mem_i.reg_wen && cmd != MEM_WR;  // stores never write rd
		end
	end

	always_ff @(posedge clk) begin
		if (mem_i.valid) begin
			wb_rd_o   <= mem_i.rd;
			wb_data_o <= (cmd == MEM_RD) ? load_data : mem_i.result;
		end
	end

	a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		cmd != MEM_NONE |-> aligned)
		else $error("mem_stage: misaligned access at %h", mem_i.result);

endmodule

`default_nettype wire

//--- logic/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

// shift-add multiplier and restoring unsigned divider, one bit per cycle
module muldiv_unit import core_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start_i,
	input  alu_op_e          op_i,
	input  logic [XLEN-1:0]  a_i,
	input  logic [XLEN-1:0]  b_i,
	output logic             busy_o,
	output logic             done_o,
	output logic [XLEN-1:0]  result_o
);

	typedef enum logic {
		MD_IDLE,
		MD_RUN
	} md_state_e;

	md_state_e               state;
	logic [MULDIV_CNT_W-1:0] cnt;
	alu_op_e                 op_q;
	logic [XLEN-1:0]         hi_q;      // product / partial remainder
	logic [XLEN-1:0]         lo_q;      // multiplier / quotient
	logic [XLEN-1:0]         opb_q;     // multiplicand / divisor
	logic [XLEN:0]           rem_sh;
	logic [XLEN:0]           rem_diff;
	logic                    rem_ge;

	// next partial remainder with one more dividend bit shifted in
	assign rem_sh   = {hi_q, lo_q[XLEN-1]};
	assign rem_diff = rem_sh - {1'b0, opb_q};
	assign rem_ge   = rem_sh >= {1'b0, opb_q};   // always true for a zero divisor

	assign busy_o   = (state == MD_RUN);
	assign result_o = (op_q == OP_DIVU) ? lo_q : hi_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= MD_IDLE;
			cnt    <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				MD_IDLE: begin
					if (start_i) begin
						state <= MD_RUN;
						cnt   <= '0;
					end
				end
				MD_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == MULDIV_CNT_W'(MULDIV_CYCLES - 1)) begin
						state  <= MD_IDLE;
						done_o <= 1'b1;     // result valid next cycle
					end
				end
				default: state <= MD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_i && state == MD_IDLE) begin
			op_q <= op_i;
			hi_q <= '0;
			if (op_i == OP_MUL) begin
				lo_q  <= b_i;
				opb_q <= a_i;
			end else begin
				lo_q  <= a_i;   // dividend shifts out the top
				opb_q <= b_i;
			end
		end else if (state == MD_RUN) begin
			if (op_q == OP_MUL) begin
				if (lo_q[0])
					hi_q <= hi_q + opb_q;
				lo_q  <= lo_q >> 1;
				opb_q <= opb_q << 1;
			end else begin
				hi_q <= rem_ge ? rem_diff[XLEN-1:0] : rem_sh[XLEN-1:0];
				lo_q <= {lo_q[XLEN-2:0], rem_ge};
			end
		end
	end

	// ex_stage must hold off a new op until the current one is finished
	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		start_i |-> !busy_o)
		else $error("muldiv_unit: start while busy");

endmodule

`default_nettype wire

//--- verification/exec_pipe_checker.sv
`timescale 1ns/1ps
`default_nettype none

// watches accepted issues and the writeback port, compares in issue order
module exec_pipe_checker import core_pkg::*; import mem_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue_valid_i,
	input  issue_t                issue_i,
	input  logic                  stall_i,
	input  logic                  wb_valid_i,
	input  logic                  wb_wen_i,
	input  logic [REG_ADDR_W-1:0] wb_rd_i,
	input  logic [XLEN-1:0]       wb_data_i,
	output int                    pending_o,
	output int                    errors_o
);

	localparam int MEM_BYTES = DMEM_WORDS * DMEM_LANES;
	localparam int BYTE_AW   = DMEM_AW + BYTE_OFF_W;

	typedef struct packed {
		logic                  wen;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
	} wb_exp_t;

	wb_exp_t    exp_q[$];
	logic [7:0] model_mem [MEM_BYTES];     // byte addressed copy of dmem
	int         pushed = 0;
	int         popped = 0;
	int         errors = 0;

	assign pending_o = pushed - popped;
	assign errors_o  = errors;

	function automatic logic [XLEN-1:0] load_model(logic [XLEN-1:0] addr, mem_size_e size,
			logic sgn);
		logic [XLEN-1:0]    v;
		logic [BYTE_AW-1:0] base;
		int                 n;
		n    = 1 << size;
		base = addr[BYTE_AW-1:0];
		v    = '0;
		for (int i = 0; i < DMEM_LANES; i++) begin
			if (i < n)
				v[i*8 +: 8] = model_mem[base + BYTE_AW'(i)];
			else if (sgn && v[n*8-1])
				v[i*8 +: 8] = 8'hff;   // sign fill above the loaded bytes
		end
		return v;
	endfunction

	function automatic void store_model(issue_t it, logic [XLEN-1:0] addr);
		logic [BYTE_AW-1:0] base;
		base = addr[BYTE_AW-1:0];
		for (int i = 0; i < DMEM_LANES; i++) begin
			if (i < (1 << it.mem_size))
				model_mem[base + BYTE_AW'(i)] = it.src2[i*8 +: 8];
		end
	endfunction

	function automatic logic [XLEN-1:0] expected_value(issue_t it);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] res;
		logic [5:0]      sh;
		a    = it.src1;
		b    = it.src2;
		sh   = b[5:0];
		addr = a + {{(XLEN-32){it.imm[31]}}, it.imm};
		case (it.op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a + ~b + 64'd1;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_SLL:  res = a << sh;
			OP_SRL:  res = a >> sh;
			OP_SRA:  res = (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
			OP_SLT:  res = (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
			OP_SLTU: res = XLEN'(a < b);
			OP_MUL:  res = a * b;
			OP_DIVU: res = (b == '0) ? '1 : a / b;
			OP_REMU: res = (b == '0) ? a : a % b;
			OP_LOAD: res = load_model(addr, it.mem_size, it.load_signed);
			default: res = addr;       // a store retires with its address
		endcase
		return res;
	endfunction

	always @(posedge clk) begin
		wb_exp_t e;
		if (rst_n && issue_valid_i && !stall_i) begin
			e.wen  = issue_i.reg_wen && issue_i.op != OP_STORE;
			e.rd   = issue_i.rd;
			e.data = expected_value(issue_i);
			if (issue_i.op == OP_STORE)
				store_model(issue_i, e.data);
			exp_q.push_back(e);
			pushed++;
		end
	end

	always @(negedge clk) begin
		wb_exp_t e;
		if (rst_n && wb_valid_i) begin
			if (exp_q.size() == 0) begin
				$display("writeback to x%0d arrived with no instruction outstanding", wb_rd_i);
				errors++;
			end else begin
				e = exp_q.pop_front();
				popped++;
				if (wb_wen_i !== e.wen) begin
					$display("MISMATCH wb_wen_o: got %h expected %h", wb_wen_i, e.wen);
					errors++;
				end
				if (e.wen && wb_rd_i !== e.rd) begin
					$display("MISMATCH wb_rd_o: got %h expected %h", wb_rd_i, e.rd);
					errors++;
				end
				if (e.wen && wb_data_i !== e.data) begin
					$display("MISMATCH wb_data_o: got %h expected %h", wb_data_i, e.data);
					errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_pipe import core_pkg::*; import mem_pkg::*; ();

	localparam int ALU_ISSUES  = 10 * 4 + 6;
	localparam int MD_ISSUES   = 3 * 3 + 2;
	localparam int MEM_ISSUES  = DMEM_WORDS + 2 * 4 * 9;
	localparam int MIX_ISSUES  = 60;
	localparam int CYCLE_LIMIT = (ALU_ISSUES + MD_ISSUES + MEM_ISSUES + MIX_ISSUES)
	                             * (MULDIV_CYCLES + 3) + 100;

	logic                  clk;
	logic                  rst_n;
	logic                  issue_valid;
	issue_t                issue;
	logic                  stall;
	logic                  wb_valid;
	logic                  wb_wen;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [XLEN-1:0]       wb_data;
	int                    pending;
	int                    chk_errors;
	integer                seed = 4;
	int                    cycles = 0;
	int                    tb_errors = 0;
	int                    err_base = 0;
	int                    n_pass = 0;
	int                    n_fail = 0;

	exec_pipe_top UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid),
		.issue_i       (issue),
		.stall_o       (stall),
		.wb_valid_o    (wb_valid),
		.wb_wen_o      (wb_wen),
		.wb_rd_o       (wb_rd),
		.wb_data_o     (wb_data)
	);

	exec_pipe_checker u_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid),
		.issue_i       (issue),
		.stall_i       (stall),
		.wb_valid_i    (wb_valid),
		.wb_wen_i      (wb_wen),
		.wb_rd_i       (wb_rd),
		.wb_data_i     (wb_data),
		.pending_o     (pending),
		.errors_o      (chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic rand64(output logic [XLEN-1:0] v);
		v = {$random(seed), $random(seed)};
	endtask

	task automatic make_alu(output issue_t it, input alu_op_e op, input logic [XLEN-1:0] a, b);
		it         = '0;
		it.op      = op;
		it.src1    = a;
		it.src2    = b;
		it.rd      = REG_ADDR_W'($random(seed));
		it.reg_wen = 1'b1;
	endtask

	// src1 chosen so that src1 + imm lands on addr
	task automatic make_mem(output issue_t it, input alu_op_e op, input mem_size_e size,
			input logic sgn, input logic [XLEN-1:0] addr, data);
		logic [31:0] imm;
		imm            = $random(seed) % 2048;
		it             = '0;
		it.op          = op;
		it.imm         = imm;
		it.src1        = addr - {{(XLEN-32){imm[31]}}, imm};
		it.src2        = data;
		it.rd          = REG_ADDR_W'($random(seed));
		it.reg_wen     = (op == OP_LOAD);
		it.mem_size    = size;
		it.load_signed = sgn;
	endtask

	task automatic rand_addr(output logic [XLEN-1:0] addr, input mem_size_e size);
		rand64(addr);
		addr = addr & ~((64'd1 << size) - 64'd1);
	endtask

	// held until an edge sees stall_o low, returns 2 ns after that edge
	task automatic send(input issue_t it);
		issue_valid = 1'b1;
		issue       = it;
		@(negedge clk);
		while (stall)
			@(negedge clk);
		@(posedge clk);
		#2;
		issue_valid = 1'b0;
	endtask

	task automatic send_muldiv(input issue_t it);
		int n;
		send(it);
		n = 0;
		@(negedge clk);
		while (stall && n <= MULDIV_CYCLES + 4) begin
			n++;
			@(negedge clk);
		end
		if (n != MULDIV_CYCLES + 1) begin
			$display("MISMATCH stall_o cycles: got %h expected %h", n, MULDIV_CYCLES + 1);
			tb_errors++;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic finish_test(input string name);
		int waited;
		int errs;
		waited = 0;
		@(negedge clk);
		while (pending != 0 && waited < MULDIV_CYCLES + 10) begin
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		if (pending != 0) begin
			$display("%s: %0d expected writebacks never arrived", name, pending);
			tb_errors++;
		end
		errs     = chk_errors + tb_errors - err_base;
		err_base = chk_errors + tb_errors;
		if (errs == 0) begin
			n_pass++;
			$display("test %s: passed", name);
		end else begin
			n_fail++;
			$display("test %s: failed with %0d errors", name, errs);
		end
	endtask

	initial begin
		issue_t          it;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] addr;
		mem_size_e       sz;
		int              k;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;

		repeat (5) begin
			@(negedge clk);
			if (wb_valid || stall) begin
				$display("wb_valid_o or stall_o went high before any issue");
				tb_errors++;
			end
		end
		finish_test("idle after reset");

		for (int op = 0; op < 10; op++) begin
			repeat (4) begin
				rand64(a);
				rand64(b);
				make_alu(it, alu_op_e'(op), a, b);
				send(it);
			end
		end
		for (int op = int'(OP_SLL); op <= int'(OP_SRA); op++) begin
			rand64(a);
			make_alu(it, alu_op_e'(op), a, 64'd0);
			send(it);
			make_alu(it, alu_op_e'(op), a, 64'd63);
			send(it);
		end
		finish_test("alu ops");

		for (int op = int'(OP_MUL); op <= int'(OP_REMU); op++) begin
			repeat (3) begin
				rand64(a);
				rand64(b);
				b = b >> ($unsigned($random(seed)) % 64);   // vary divisor size
				make_alu(it, alu_op_e'(op), a, b);
				send_muldiv(it);
			end
		end
		rand64(a);
		make_alu(it, OP_DIVU, a, '0);
		send_muldiv(it);
		make_alu(it, OP_REMU, a, '0);
		send_muldiv(it);
		finish_test("multicycle ops");

		// every word gets a known value before any load
		for (int w = 0; w < DMEM_WORDS; w++) begin
			addr = XLEN'(w * DMEM_LANES);
			make_mem(it, OP_STORE, MEM_DOUBLE, 1'b0, addr,
			         {~addr[31:0], addr[31:0] ^ 32'h5a5a_5a5a});
			send(it);
		end
		repeat (2) begin
			for (int s = 0; s < 4; s++) begin
				rand_addr(addr, mem_size_e'(s));
				rand64(b);
				make_mem(it, OP_STORE, mem_size_e'(s), 1'b0, addr, b);
				send(it);
				for (int l = 0; l < 8; l++) begin
					a = addr & ~((64'd1 << (l / 2)) - 64'd1);
					make_mem(it, OP_LOAD, mem_size_e'(l / 2), l[0], a, '0);
					send(it);
				end
			end
		end
		finish_test("stores and loads");

		repeat (MIX_ISSUES) begin
			k = $unsigned($random(seed)) % 16;
			rand64(a);
			rand64(b);
			sz = mem_size_e'(b[9:8]);
			if (k < 10) begin
				make_alu(it, alu_op_e'(k), a, b);
			end else if (k < 14) begin
				rand_addr(addr, sz);
				make_mem(it, (k < 12) ? OP_LOAD : OP_STORE, sz, b[0], addr, b);
			end else begin
				make_alu(it, alu_op_e'(int'(OP_MUL) + int'(a[1:0]) % 3), a, b >> a[7:2]);
			end
			send(it);
		end
		finish_test("mixed stream");

		$display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
